// File: flist.f
crypto_pkg.sv
crypto_bitmanip.sv
crypto_sha256.sv
prng_ctrl_fsm.sv
prng_warmup_counter.sv
prng_lfsr.sv
crypto_scalar_fu.sv
crypto_scalar_fu_props.sv
tb_crypto_scalar_fu.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator, then judge the log
rm -f sim.log
verilator --binary --timing --assert --top-module tb_crypto_scalar_fu -f flist.f \
  && ./obj_dir/Vtb_crypto_scalar_fu > sim.log 2>&1 \
  || echo "Something failed" >> sim.log
cat sim.log
grep -q "Something failed" sim.log && echo "FAIL" && exit 1 || echo "PASS"

// File: tb_crypto_scalar_fu.sv
`timescale 1ns/10ps

module tb_crypto_scalar_fu;

  localparam int MAX_CYCLES = 2000; // Tests need well under 1,200

  logic                  clk_i, rst_ni, valid_i;
  crypto_pkg::opcode_t   opcode_i;
  crypto_pkg::instr_t    instr_i;
  crypto_pkg::xlen_t     rs1_i, rs2_i, result_o, exp_result;
  crypto_pkg::reg_addr_t rd_i, rd_o, exp_rd;
  crypto_pkg::id_t       id_i, id_o, exp_id;
  logic                  valid_o, we_o, exp_valid, exp_we;
  logic [31:0]           lcg_state = 32'hbcdb_7fdf;
  crypto_pkg::prng_state_t m_state; // Generator model
  int                    m_fsm;     // 0 idle, 1 warm-up, 2 ready
  int                    m_cnt;
  int                    cycles = 0;

  crypto_scalar_fu crypto_scalar_fu_i (.*);

  bind crypto_scalar_fu crypto_scalar_fu_props props_i (
    .clk_i(clk_i), .rst_ni(rst_ni), .valid_i(valid_i), .opcode_i(opcode_i),
    .valid_o(valid_o), .we_o(we_o), .result_o(result_o), .rd_o(rd_o), .id_o(id_o)
  );

  ////////////////////////////////////////
  // Reference functions
  ////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {lcg_state[15:0], lcg_state[31:16]}; // Low state bits have short periods
  endfunction

  function automatic crypto_pkg::xlen_t rand64();
    return {next_rand(), next_rand()};
  endfunction

  function automatic crypto_pkg::xlen_t reverse_byte_bits(input crypto_pkg::xlen_t x);
    crypto_pkg::xlen_t r;
    for (int i = 0; i < 64; i++) r[i] = x[(i & ~7) | (7 - (i & 7))];
    return r;
  endfunction

  function automatic crypto_pkg::xlen_t pack_operands(input logic [1:0] sel,
                                                      input crypto_pkg::xlen_t a, b);
    crypto_pkg::xlen_t r;
    r = '0; // Reserved form
    case (sel)
      2'b00: r = {b[31:0], a[31:0]};
      2'b01: r = {{32{b[15]}}, b[15:0], a[15:0]};
      2'b10: r = {48'h0, b[7:0], a[7:0]};
      default: ;
    endcase
    return r;
  endfunction

  function automatic logic [31:0] rotr(input logic [31:0] x, input int n);
    logic [63:0] d;
    d = {x, x} >> n;
    return d[31:0];
  endfunction

  function automatic crypto_pkg::xlen_t sha256_sigma_sum(input logic [1:0] op,
                                                         input logic [31:0] w);
    logic [31:0] r;
    case (op)
      2'd0: r = rotr(w, 2) ^ rotr(w, 13) ^ rotr(w, 22);
      2'd1: r = rotr(w, 6) ^ rotr(w, 11) ^ rotr(w, 25);
      2'd2: r = rotr(w, 7) ^ rotr(w, 18) ^ (w >> 3);
      default: r = rotr(w, 17) ^ rotr(w, 19) ^ (w >> 10);
    endcase
    return {{32{r[31]}}, r};
  endfunction

  function automatic crypto_pkg::prng_state_t lfsr_step(input crypto_pkg::prng_state_t s);
    return (s >> 1) ^ (s[0] ? crypto_pkg::PRNG_TAPS : '0);
  endfunction

  ////////////////////////////////////////
  // Clock, model and checks
  ////////////////////////////////////////

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i or negedge rst_ni) begin : model
    logic [2:0]        sub;
    logic              legal, prng;
    crypto_pkg::xlen_t res;
    if (!rst_ni) begin
      {exp_valid, exp_we, exp_result, exp_rd, exp_id} <= '0;
      m_state = '0;
      m_fsm   = 0;
      m_cnt   = 0;
    end else begin
      sub   = instr_i[crypto_pkg::PRNG_OP_LSB +: 3];
      legal = valid_i && opcode_i inside {crypto_pkg::OP_BREV8, crypto_pkg::OP_PACK,
                                          crypto_pkg::OP_SHA256, crypto_pkg::OP_PRNG};
      prng  = valid_i && opcode_i == crypto_pkg::OP_PRNG;
      res   = '0;
      case (opcode_i)
        crypto_pkg::OP_BREV8:  res = reverse_byte_bits(rs1_i);
        crypto_pkg::OP_PACK:   res = pack_operands({instr_i[13], instr_i[3]}, rs1_i, rs2_i);
        crypto_pkg::OP_SHA256: res = sha256_sigma_sum(instr_i[21:20], rs1_i[31:0]);
        crypto_pkg::OP_PRNG:   res = (sub == crypto_pkg::PRNG_READ && m_fsm == 2) ?
                                     m_state[63:0] : '0;
        default: ;
      endcase
      exp_valid  <= legal;
      exp_we     <= legal && !(prng && sub != crypto_pkg::PRNG_READ);
      exp_result <= legal ? res : '0;
      exp_rd     <= legal ? rd_i : '0;
      exp_id     <= legal ? id_i : '0;
      if (prng && sub == crypto_pkg::PRNG_CLEAR) begin // Clear wins
        m_state = '0;
        m_fsm   = 0;
      end else if (prng && sub == crypto_pkg::PRNG_SEED) begin
        m_state = {rs1_i, rs2_i};
        m_fsm   = 1;
        m_cnt   = 0;
      end else if (m_fsm == 1) begin
        m_state = lfsr_step(m_state);
        m_cnt++;
        if (m_cnt == crypto_pkg::PRNG_WARMUP) m_fsm = 2;
      end else if (m_fsm == 2 && prng && sub == crypto_pkg::PRNG_STEP) begin
        m_state = lfsr_step(m_state);
      end
    end
  end

  task automatic report_mismatch(input string name, input logic [63:0] got, exp);
    $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
    $display("Something failed");
    $fatal(1, "Output mismatch");
  endtask

  chk_valid: assert property (@(posedge clk_i) valid_o == exp_valid)
    else report_mismatch("valid_o", 64'($sampled(valid_o)), 64'($sampled(exp_valid)));
  chk_we: assert property (@(posedge clk_i) we_o == exp_we)
    else report_mismatch("we_o", 64'($sampled(we_o)), 64'($sampled(exp_we)));
  chk_result: assert property (@(posedge clk_i) result_o == exp_result)
    else report_mismatch("result_o", $sampled(result_o), $sampled(exp_result));
  chk_rd: assert property (@(posedge clk_i) rd_o == exp_rd)
    else report_mismatch("rd_o", 64'($sampled(rd_o)), 64'($sampled(exp_rd)));
  chk_id: assert property (@(posedge clk_i) id_o == exp_id)
    else report_mismatch("id_o", 64'($sampled(id_o)), 64'($sampled(exp_id)));

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      $display("Timeout, the test did not finish within %0d cycles", MAX_CYCLES);
      $display("Something failed");
      $fatal(1, "Cycle limit reached");
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic issue(input crypto_pkg::opcode_t op, input crypto_pkg::instr_t ins,
                       input crypto_pkg::xlen_t a, b);
    @(posedge clk_i);
    #1;
    valid_i  = 1'b1;
    opcode_i = op;
    instr_i  = ins;
    rs1_i    = a;
    rs2_i    = b;
    rd_i     = crypto_pkg::reg_addr_t'(next_rand());
    id_i     = crypto_pkg::id_t'(next_rand());
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
      valid_i = 1'b0;
    end
  endtask

  task automatic prng_cmd(input logic [2:0] sub);
    crypto_pkg::instr_t ins;
    ins = next_rand();
    ins[crypto_pkg::PRNG_OP_LSB +: 3] = sub;
    issue(crypto_pkg::OP_PRNG, ins, rand64(), rand64());
  endtask

  initial begin : stimulus
    logic [31:0] rnd;
    valid_i  = 1'b0;
    opcode_i = crypto_pkg::OP_BREV8;
    {instr_i, rs1_i, rs2_i, rd_i, id_i} = '0;
    rst_ni   = 1'b1;
    #2;
    rst_ni = 1'b0;
    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    idle(3);
    issue(crypto_pkg::opcode_t'(4'h0), next_rand(), rand64(), rand64()); // Illegal
    issue(crypto_pkg::opcode_t'(4'hf), next_rand(), rand64(), rand64());
    idle(2);
    repeat (200) begin
      rnd = next_rand();
      issue(rnd[31] ? crypto_pkg::OP_PACK : crypto_pkg::OP_BREV8, next_rand(), rand64(), rand64());
    end
    repeat (200) issue(crypto_pkg::OP_SHA256, next_rand(), rand64(), rand64());
    prng_cmd(crypto_pkg::PRNG_SEED);
    repeat (5) prng_cmd(crypto_pkg::PRNG_READ); // Zero during warm-up
    prng_cmd(crypto_pkg::PRNG_STEP);             // Ignored in warm-up
    idle(14);
    prng_cmd(crypto_pkg::PRNG_READ);
    prng_cmd(crypto_pkg::PRNG_STEP);
    prng_cmd(crypto_pkg::PRNG_READ);
    repeat (3) prng_cmd(crypto_pkg::PRNG_STEP);
    prng_cmd(crypto_pkg::PRNG_READ);
    prng_cmd(crypto_pkg::PRNG_CLEAR);
    prng_cmd(crypto_pkg::PRNG_READ);
    prng_cmd(crypto_pkg::PRNG_SEED);
    idle(6);
    prng_cmd(crypto_pkg::PRNG_SEED); // Restart mid warm-up
    idle(10);
    prng_cmd(crypto_pkg::PRNG_READ);
    idle(8);
    prng_cmd(crypto_pkg::PRNG_READ);
    repeat (200) begin
      rnd = next_rand();
      prng_cmd(rnd[30:28]); // Includes the undefined sub-ops
    end
    idle(3);
    $display("Everything OK");
    $finish;
  end

endmodule

// File: crypto_scalar_fu_props.sv
`timescale 1ns/10ps

module crypto_scalar_fu_props (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic                  valid_i,
  input crypto_pkg::opcode_t   opcode_i,
  input logic                  valid_o,
  input logic                  we_o,
  input crypto_pkg::xlen_t     result_o,
  input crypto_pkg::reg_addr_t rd_o,
  input crypto_pkg::id_t       id_o
);

  logic legal_issue;

  assign legal_issue = valid_i && (opcode_i inside {crypto_pkg::OP_BREV8, crypto_pkg::OP_PACK,
                                                    crypto_pkg::OP_SHA256, crypto_pkg::OP_PRNG});

  // One-cycle latency, no stalls
  issue_gives_result: assert property (@(posedge clk_i) disable iff (!rst_ni)
    legal_issue |=> valid_o)
    else $error("A legal issue was not followed by valid_o one cycle later");

  we_needs_valid: assert property (@(posedge clk_i) we_o |-> valid_o)
    else $error("we_o was high without valid_o");

  zero_in_reset: assert property (@(posedge clk_i)
    !rst_ni |-> (!valid_o && !we_o && result_o == '0 && rd_o == '0 && id_o == '0))
    else $error("Outputs were not zero during reset");

endmodule

// File: crypto_scalar_fu.sv
`timescale 1ns/10ps

module crypto_scalar_fu (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  valid_i,
  input  crypto_pkg::opcode_t   opcode_i,
  input  crypto_pkg::instr_t    instr_i,
  input  crypto_pkg::xlen_t     rs1_i,
  input  crypto_pkg::xlen_t     rs2_i,
  input  crypto_pkg::reg_addr_t rd_i,
  input  crypto_pkg::id_t       id_i,
  output logic                  valid_o,
  output logic                  we_o,
  output crypto_pkg::xlen_t     result_o,
  output crypto_pkg::reg_addr_t rd_o,
  output crypto_pkg::id_t       id_o
);

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  crypto_pkg::pack_op_t   pack_op;
  crypto_pkg::sha256_op_t sha_op;
  crypto_pkg::prng_op_t   prng_op;
  logic                   prng_issue;
  logic                   seed, step, clear;

  assign pack_op = crypto_pkg::pack_op_t'({instr_i[crypto_pkg::PACK_SEL_HI_BIT],
                                           instr_i[crypto_pkg::PACK_SEL_LO_BIT]});
  assign sha_op  = crypto_pkg::sha256_op_t'(instr_i[crypto_pkg::SHA_OP_LSB +: 2]);
  assign prng_op = crypto_pkg::prng_op_t'(instr_i[crypto_pkg::PRNG_OP_LSB +: 3]);

  assign prng_issue = valid_i && (opcode_i == crypto_pkg::OP_PRNG);
  assign seed       = prng_issue && (prng_op == crypto_pkg::PRNG_SEED);  // One-cycle strobes
  assign step       = prng_issue && (prng_op == crypto_pkg::PRNG_STEP);
  assign clear      = prng_issue && (prng_op == crypto_pkg::PRNG_CLEAR);

  ////////////////////////////////////////
  // Datapath units
  ////////////////////////////////////////

  crypto_pkg::xlen_t       bitmanip_res, sha256_res;
  crypto_pkg::prng_state_t prng_state;
  logic                    load, prng_clr, advance, warmup, ready, done;

  crypto_bitmanip bitmanip_i (
    .rs1_i      (rs1_i),
    .rs2_i      (rs2_i),
    .pack_op_i  (pack_op),
    .sel_pack_i (opcode_i == crypto_pkg::OP_PACK),
    .result_o   (bitmanip_res)
  );

  crypto_sha256 sha256_i (
    .rs1_i    (rs1_i),
    .op_i     (sha_op),
    .result_o (sha256_res)
  );

  prng_ctrl_fsm prng_ctrl_fsm_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .seed_i    (seed),
    .step_i    (step),
    .clear_i   (clear),
    .done_i    (done),
    .load_o    (load),
    .clear_o   (prng_clr),
    .advance_o (advance),
    .warmup_o  (warmup),
    .ready_o   (ready)
  );

  prng_warmup_counter prng_warmup_counter_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .start_i (load),
    .en_i    (warmup),
    .done_o  (done)
  );

  prng_lfsr prng_lfsr_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .load_i    (load),
    .clear_i   (prng_clr),
    .advance_i (advance),
    .seed_i    ({rs1_i, rs2_i}), // rs1 forms the upper half
    .state_o   (prng_state)
  );

  ////////////////////////////////////////
  // Result select and output register
  ////////////////////////////////////////

  crypto_pkg::xlen_t result_d;
  logic              valid_d, we_d;

  always_comb begin
    valid_d  = valid_i;
    we_d     = valid_i;
    result_d = '0;
    case (opcode_i)
      crypto_pkg::OP_BREV8,
      crypto_pkg::OP_PACK:   result_d = bitmanip_res;
      crypto_pkg::OP_SHA256: result_d = sha256_res;
      crypto_pkg::OP_PRNG: begin
        we_d = valid_i && (prng_op == crypto_pkg::PRNG_READ); // Only read writes rd
        if (prng_op == crypto_pkg::PRNG_READ && ready) begin
          result_d = prng_state[63:0]; // State before this edge
        end
      end
      default: begin
        valid_d = 1'b0; // Illegal opcode
        we_d    = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_o  <= 1'b0;
      we_o     <= 1'b0;
      result_o <= '0;
      rd_o     <= '0;
      id_o     <= '0;
    end else begin
      valid_o  <= valid_d;
      we_o     <= we_d;
      result_o <= valid_d ? result_d : '0; // Idle cycles leave zeros
      rd_o     <= valid_d ? rd_i : '0;
      id_o     <= valid_d ? id_i : '0;
    end
  end

endmodule

// File: prng_lfsr.sv
`timescale 1ns/10ps

module prng_lfsr (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    load_i,
  input  logic                    clear_i,
  input  logic                    advance_i,
  input  crypto_pkg::prng_state_t seed_i,
  output crypto_pkg::prng_state_t state_o
);

  crypto_pkg::prng_state_t state_q;
  crypto_pkg::prng_state_t state_step;

  // Galois step, shift right and fold the dropped bit back in
  assign state_step = {1'b0, state_q[127:1]} ^
                      (state_q[0] ? crypto_pkg::PRNG_TAPS : '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= '0;
    end else if (clear_i) begin
      state_q <= '0;
    end else if (load_i) begin
      state_q <= seed_i;
    end else if (advance_i) begin
      state_q <= state_step;
    end
  end

  assign state_o = state_q;

endmodule

// File: prng_warmup_counter.sv
`timescale 1ns/10ps

module prng_warmup_counter (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic start_i,
  input  logic en_i,
  output logic done_o
);

  crypto_pkg::warmup_cnt_t cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (start_i) begin
      cnt_q <= '0; // New seed, count from zero
    end else if (en_i) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // High in the cycle whose edge takes the last warm-up step
  assign done_o = en_i && (cnt_q == crypto_pkg::warmup_cnt_t'(crypto_pkg::PRNG_WARMUP - 1));

endmodule

// File: prng_ctrl_fsm.sv
`timescale 1ns/10ps

module prng_ctrl_fsm (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic seed_i,
  input  logic step_i,
  input  logic clear_i,
  input  logic done_i,
  output logic load_o,
  output logic clear_o,
  output logic advance_o,
  output logic warmup_o,
  output logic ready_o
);

  crypto_pkg::prng_fsm_t state_q, state_d;

  always_comb begin
    state_d = state_q;
    if (clear_i) begin
      state_d = crypto_pkg::ST_IDLE; // Clear beats everything
    end else if (seed_i) begin
      state_d = crypto_pkg::ST_WARMUP; // Seed restarts warm-up from any state
    end else begin
      case (state_q)
        crypto_pkg::ST_WARMUP: begin
          if (done_i) begin
            state_d = crypto_pkg::ST_READY;
          end
        end
        crypto_pkg::ST_READY: state_d = crypto_pkg::ST_READY;
        default:              state_d = crypto_pkg::ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= crypto_pkg::ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign warmup_o  = (state_q == crypto_pkg::ST_WARMUP);
  assign ready_o   = (state_q == crypto_pkg::ST_READY);
  assign load_o    = seed_i && !clear_i;
  assign clear_o   = clear_i;

  // Free-running during warm-up, on request once ready
  assign advance_o = warmup_o || (ready_o && step_i);

endmodule

// File: crypto_sha256.sv
`timescale 1ns/10ps

module crypto_sha256 (
  input  crypto_pkg::xlen_t      rs1_i,
  input  crypto_pkg::sha256_op_t op_i,
  output crypto_pkg::xlen_t      result_o
);

  function automatic crypto_pkg::word32_t ror32(input crypto_pkg::word32_t x,
                                                input int unsigned n);
    return (x >> n) | (x << (32 - n));
  endfunction

  crypto_pkg::word32_t w;
  crypto_pkg::word32_t res;

  assign w = rs1_i[31:0]; // Only the low word is used

  always_comb begin
    case (op_i)
      crypto_pkg::SHA_SUM0: res = ror32(w, 2) ^ ror32(w, 13) ^ ror32(w, 22);
      crypto_pkg::SHA_SUM1: res = ror32(w, 6) ^ ror32(w, 11) ^ ror32(w, 25);
      crypto_pkg::SHA_SIG0: res = ror32(w, 7) ^ ror32(w, 18) ^ (w >> 3);
      default:              res = ror32(w, 17) ^ ror32(w, 19) ^ (w >> 10); // sig1
    endcase
  end

  assign result_o = {{32{res[31]}}, res}; // Sign-extend to 64 bits

endmodule

// File: crypto_bitmanip.sv
`timescale 1ns/10ps

module crypto_bitmanip (
  input  crypto_pkg::xlen_t    rs1_i,
  input  crypto_pkg::xlen_t    rs2_i,
  input  crypto_pkg::pack_op_t pack_op_i,
  input  logic                 sel_pack_i,
  output crypto_pkg::xlen_t    result_o
);

  crypto_pkg::xlen_t brev8_res;
  crypto_pkg::xlen_t pack_res;

  // Bit reverse inside every byte, byte order kept
  always_comb begin
    for (int b = 0; b < 8; b++) begin
      for (int i = 0; i < 8; i++) begin
        brev8_res[8*b + i] = rs1_i[8*b + 7 - i];
      end
    end
  end

  always_comb begin
    case (pack_op_i)
      crypto_pkg::PACK_PACK: begin
        pack_res = {rs2_i[31:0], rs1_i[31:0]};
      end
      crypto_pkg::PACK_PACKW: begin
        pack_res = {{32{rs2_i[15]}}, rs2_i[15:0], rs1_i[15:0]}; // Sign from bit 31
      end
      crypto_pkg::PACK_PACKH: begin
        pack_res = {48'b0, rs2_i[7:0], rs1_i[7:0]};
      end
      default: begin
        pack_res = '0; // Reserved encoding
      end
    endcase
  end

  assign result_o = sel_pack_i ? pack_res : brev8_res;

endmodule

// File: crypto_pkg.sv
package crypto_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  typedef logic [63:0]  xlen_t;       // Operand and result word
  typedef logic [31:0]  word32_t;     // SHA-256 word
  typedef logic [4:0]   reg_addr_t;   // Architectural register index
  typedef logic [31:0]  instr_t;      // Raw instruction word
  typedef logic [3:0]   id_t;         // Issue tag
  typedef logic [127:0] prng_state_t; // Generator state

  ////////////////////////////////////////
  // Opcodes and sub-operations
  ////////////////////////////////////////

  typedef enum logic [3:0] {
    OP_BREV8  = 4'h1,
    OP_PACK   = 4'h2,
    OP_SHA256 = 4'h3,
    OP_PRNG   = 4'h4
  } opcode_t; // All other codes are illegal

  typedef enum logic [1:0] {
    PACK_PACK  = 2'b00,
    PACK_PACKW = 2'b01,
    PACK_PACKH = 2'b10,
    PACK_RSVD  = 2'b11  // Zero result
  } pack_op_t;

  typedef enum logic [1:0] {
    SHA_SUM0 = 2'd0,
    SHA_SUM1 = 2'd1,
    SHA_SIG0 = 2'd2,
    SHA_SIG1 = 2'd3
  } sha256_op_t;

  typedef enum logic [2:0] {
    PRNG_READ  = 3'b100,
    PRNG_SEED  = 3'b101,
    PRNG_STEP  = 3'b110,
    PRNG_CLEAR = 3'b111
  } prng_op_t;

  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    ST_WARMUP = 2'd1,
    ST_READY  = 2'd2
  } prng_fsm_t;

  ////////////////////////////////////////
  // Instruction fields and generator constants
  ////////////////////////////////////////

  localparam int unsigned PACK_SEL_HI_BIT = 13;
  localparam int unsigned PACK_SEL_LO_BIT = 3;
  localparam int unsigned SHA_OP_LSB      = 20;
  localparam int unsigned PRNG_OP_LSB     = 25;

  localparam int unsigned PRNG_WARMUP = 16;               // Steps after a seed
  localparam prng_state_t PRNG_TAPS   = {8'hE1, 120'b0};  // Feedback polynomial

  typedef logic [$clog2(PRNG_WARMUP)-1:0] warmup_cnt_t;   // Warm-up step count

endpackage
